// File: sim.f
+incdir+design
design/soc_pkg.sv
design/soc_bus_bridge.sv
design/soc_bram.sv
design/soc_ctrl_regs.sv
design/soc_uart_tx.sv
design/soc_led_pwm.sv
design/soc_periph_top.sv
verification/soc_assert.sv
verification/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module soc_tb -o soc_sim \
	> build.log 2>&1 && ./obj_dir/soc_sim > sim.log 2>&1 || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// File: verification/soc_tb.sv
// SoC peripheral testbench

`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_tb;
	localparam int CLK_NS = 4;
	// RAM, UART and PWM traffic come to about 1250 cycles
	localparam int TEST_CYCLES = 1250;
	localparam int WATCHDOG_NS = 4 * TEST_CYCLES * CLK_NS;
	localparam int UART_DIV = 3;

	logic               clk_24m;
	logic               rst;
	soc_pkg::mem_req_t  mem_req;
	soc_pkg::mem_rsp_t  mem_rsp;
	logic               uart_tx;
	logic [2:0]         rgb;
	soc_pkg::boot_req_t boot;

	int          errors;
	int          checks;
	int          tests;
	int          failed_tests;
	logic [31:0] ram_model [2**`SOC_BRAM_AW];

	soc_periph_top i_soc_periph_top (
		.clk_24m   (clk_24m),
		.rst       (rst),
		.mem_req_i (mem_req),
		.mem_rsp_o (mem_rsp),
		.uart_tx_o (uart_tx),
		.rgb_o     (rgb),
		.boot_o    (boot)
	);

	initial begin
		clk_24m = 1'b0;
		forever #(CLK_NS / 2) clk_24m = ~clk_24m;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] slave_addr(input int slv, input int idx);
		return {`SOC_REGION_WB, 12'd0, 2'(slv), 10'd0, 4'(idx), 2'b00};
	endfunction

	// Slave registers take 3 edges, everything else 1
	function automatic int expected_edges(input logic [31:0] addr);
		if (addr[31:30] == `SOC_REGION_WB && addr[17:16] < `SOC_WB_N)
			return 3;
		else
			return 1;
	endfunction

	function automatic logic [31:0] apply_strobe(input logic [31:0] old,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb, output logic [31:0] rdata);
		int edges;
		@(negedge clk_24m);
		mem_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
		edges = 0;
		rdata = '0;
		do begin
			@(posedge clk_24m);
			edges++;
			@(negedge clk_24m);
		end while (!mem_rsp.ready && edges < 8);
		if (mem_rsp.ready) begin
			rdata = mem_rsp.rdata;
			check($sformatf("ready edges at %h", addr), edges, expected_edges(addr));
		end else begin
			errors++;
			$display("No ready from the DUT within 8 cycles for address %h", addr);
		end
		mem_req.valid = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb);
		logic [31:0] unused;
		bus_access(addr, wdata, wstrb, unused);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
		bus_access(addr, 32'd0, 4'h0, rdata);
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		if (errors != err_start)
			failed_tests++;
		$display("test %s: %s", name, (errors == err_start) ? "ok" : "errors");
	endtask

	task automatic test_ram;
		int          err_start;
		logic [7:0]  waddr [16];
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic [31:0] rdata;
		err_start = errors;
		for (int i = 0; i < 16; i++) begin
			waddr[i] = 8'($urandom);
			wdata = $urandom;
			bus_write({22'd0, waddr[i], 2'b00}, wdata, 4'hf);
			ram_model[waddr[i]] = wdata;
			wdata = $urandom;
			wstrb = 4'($urandom);
			bus_write({22'd0, waddr[i], 2'b00}, wdata, wstrb);
			ram_model[waddr[i]] = apply_strobe(ram_model[waddr[i]], wdata, wstrb);
		end
		for (int i = 0; i < 16; i++) begin
			bus_read({22'd0, waddr[i], 2'b00}, rdata);
			check("ram rdata", rdata, ram_model[waddr[i]]);
		end
		end_test("ram", err_start);
	endtask

	task automatic test_regions;
		int          err_start;
		logic [31:0] rdata;
		err_start = errors;
		bus_write(32'h4000_0010, $urandom, 4'hf);
		bus_read(32'h4000_0010, rdata);
		check("empty region rdata", rdata, 32'd0);
		bus_read(32'hc000_0000, rdata);
		check("empty region rdata", rdata, 32'd0);
		bus_read(slave_addr(3, 0), rdata);
		check("slave 3 rdata", rdata, 32'd0);
		bus_read(slave_addr(`SOC_REG_LED, 0), rdata);
		check("led duty after reset", rdata, 32'd0);
		end_test("regions", err_start);
	endtask

	task automatic test_ctrl;
		int          err_start;
		logic [31:0] w;
		logic [31:0] rdata;
		err_start = errors;
		w = $urandom;
		bus_write(slave_addr(`SOC_REG_CTRL, 1), w, 4'hf);
		check("boot_o", {29'd0, boot}, {29'd0, w[2], w[1:0]});
		bus_read(slave_addr(`SOC_REG_CTRL, 1), rdata);
		check("boot reg rdata", rdata, {29'd0, w[2:0]});
		w = $urandom;
		bus_write(slave_addr(`SOC_REG_CTRL, 0), w, 4'hf);
		bus_read(slave_addr(`SOC_REG_CTRL, 0), rdata);
		check("led enable rdata", rdata, {29'd0, w[2:0]});
		bus_read(slave_addr(`SOC_REG_CTRL, 5), rdata);
		check("ctrl unused reg rdata", rdata, 32'd0);
		bus_write(slave_addr(`SOC_REG_CTRL, 0), 32'd0, 4'hf);
		end_test("ctrl", err_start);
	endtask

	// Samples near the middle of each bit from the falling start edge
	task automatic capture_frame(output logic [9:0] frame);
		@(negedge uart_tx);
		repeat ((UART_DIV + 1) / 2) @(negedge clk_24m);
		for (int i = 0; i < 10; i++) begin
			frame[i] = uart_tx;
			if (i < 9)
				repeat (UART_DIV + 1) @(negedge clk_24m);
		end
	endtask

	task automatic test_uart;
		int          err_start;
		int          polls;
		int          low_cycles;
		logic [7:0]  tx_byte;
		logic [9:0]  frame;
		logic [31:0] rdata;
		err_start = errors;
		bus_write(slave_addr(`SOC_REG_UART, 1), UART_DIV, 4'hf);
		bus_read(slave_addr(`SOC_REG_UART, 1), rdata);
		check("uart divisor", rdata, UART_DIV);
		tx_byte = 8'($urandom);
		fork
			begin
				bus_write(slave_addr(`SOC_REG_UART, 0), {24'd0, tx_byte}, 4'hf);
				bus_read(slave_addr(`SOC_REG_UART, 0), rdata);
				check("uart busy during frame", rdata, 32'd1);
				bus_write(slave_addr(`SOC_REG_UART, 0), {24'd0, ~tx_byte}, 4'hf);
			end
			capture_frame(frame);
		join
		check("uart_tx_o frame", frame, {1'b1, tx_byte, 1'b0});
		// A dropped byte must never reach the line
		polls = 0;
		low_cycles = 0;
		fork
			begin
				do begin
					bus_read(slave_addr(`SOC_REG_UART, 0), rdata);
					polls++;
				end while (rdata[0] && polls < 20);
			end
			repeat (100) begin
				@(negedge clk_24m);
				if (uart_tx !== 1'b1)
					low_cycles++;
			end
		join
		check("uart busy after frame", rdata, 32'd0);
		check("uart_tx_o low cycles after frame", low_cycles, 0);
		end_test("uart", err_start);
	endtask

	task automatic test_pwm;
		int          err_start;
		int          high_cnt [3];
		int          lit;
		logic [7:0]  duty [3];
		logic [31:0] rdata;
		err_start = errors;
		for (int k = 0; k < 3; k++) begin
			duty[k] = 8'($urandom);
			bus_write(slave_addr(`SOC_REG_LED, k), {24'd0, duty[k]}, 4'hf);
			bus_read(slave_addr(`SOC_REG_LED, k), rdata);
			check($sformatf("duty %0d rdata", k), rdata, {24'd0, duty[k]});
		end
		bus_write(slave_addr(`SOC_REG_CTRL, 0), 32'h7, 4'hf);
		repeat (2) begin
			repeat ($urandom % 32) @(negedge clk_24m);
			high_cnt = '{0, 0, 0};
			repeat (256) begin
				@(negedge clk_24m);
				for (int k = 0; k < 3; k++)
					high_cnt[k] += int'(rgb[k]);
			end
			for (int k = 0; k < 3; k++)
				check($sformatf("rgb_o[%0d] high cycles", k), high_cnt[k], duty[k]);
		end
		bus_write(slave_addr(`SOC_REG_CTRL, 0), 32'h0, 4'hf);
		lit = 0;
		repeat (256) begin
			@(negedge clk_24m);
			if (rgb !== 3'b000)
				lit++;
		end
		check("rgb_o lit cycles while disabled", lit, 0);
		end_test("pwm", err_start);
	endtask

	initial begin
		void'($urandom(32'hedac));
		rst = 1'b1;
		mem_req = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		repeat (5) @(posedge clk_24m);
		@(negedge clk_24m);
		rst = 1'b0;
		test_ram();
		test_regions();
		test_ctrl();
		test_uart();
		test_pwm();
		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: verification/soc_assert.sv
// Bus and output assertions

`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_assert (
	input logic                 clk_24m,
	input logic                 rst,
	input soc_pkg::mem_rsp_t    mem_rsp_i,
	input logic [`SOC_WB_N-1:0] wb_cyc_i,
	input logic                 tx_busy_i,
	input logic                 uart_tx_i,
	input logic [2:0]           ch_en_i,
	input logic [2:0]           rgb_i
);
	ready_one_cycle: assert property (@(posedge clk_24m) disable iff (rst)
		mem_rsp_i.ready |=> !mem_rsp_i.ready)
		else $error("ready high on two cycles in a row");

	cyc_onehot: assert property (@(posedge clk_24m) disable iff (rst) $onehot0(wb_cyc_i))
		else $error("more than one cyc line high");

	// Line idles high
	tx_idle_high: assert property (@(posedge clk_24m) disable iff (rst)
		!tx_busy_i |-> uart_tx_i)
		else $error("uart_tx_o low while the transmitter is idle");

	rgb_gated: assert property (@(posedge clk_24m) disable iff (rst)
		(rgb_i & ~ch_en_i) == 3'b000)
		else $error("rgb_o high on a disabled channel");

endmodule

bind soc_periph_top soc_assert i_assert (
	.clk_24m   (clk_24m),
	.rst       (rst),
	.mem_rsp_i (mem_rsp_o),
	.wb_cyc_i  (wb_cyc),
	.tx_busy_i (i_uart.busy),
	.uart_tx_i (uart_tx_o),
	.ch_en_i   (ch_en),
	.rgb_i     (rgb_o)
);

// File: design/soc_periph_top.sv
// SoC peripheral top level

`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_periph_top (
	input  logic               clk_24m,
	input  logic               rst,
	input  soc_pkg::mem_req_t  mem_req_i,
	output soc_pkg::mem_rsp_t  mem_rsp_o,
	output logic               uart_tx_o,
	output logic [2:0]         rgb_o,
	output soc_pkg::boot_req_t boot_o
);
	soc_pkg::bram_req_t   bram_req;
	logic [31:0]          bram_rdata;
	soc_pkg::wb_req_t     wb_req;
	logic [`SOC_WB_N-1:0] wb_cyc;
	soc_pkg::wb_rsp_t     wb_rsp [`SOC_WB_N];
	logic [2:0]           ch_en;

	soc_bus_bridge i_bridge (
		.clk_24m      (clk_24m),
		.rst          (rst),
		.mem_req_i    (mem_req_i),
		.mem_rsp_o    (mem_rsp_o),
		.bram_req_o   (bram_req),
		.bram_rdata_i (bram_rdata),
		.wb_req_o     (wb_req),
		.wb_cyc_o     (wb_cyc),
		.wb_rsp_i     (wb_rsp)
	);

	soc_bram i_bram (
		.clk_24m (clk_24m),
		.req_i   (bram_req),
		.rdata_o (bram_rdata)
	);

	soc_ctrl_regs i_ctrl (
		.clk_24m  (clk_24m),
		.rst      (rst),
		.wb_req_i (wb_req),
		.wb_cyc_i (wb_cyc[`SOC_REG_CTRL]),
		.wb_rsp_o (wb_rsp[`SOC_REG_CTRL]),
		.ch_en_o  (ch_en),
		.boot_o   (boot_o)
	);

	soc_uart_tx i_uart (
		.clk_24m   (clk_24m),
		.rst       (rst),
		.wb_req_i  (wb_req),
		.wb_cyc_i  (wb_cyc[`SOC_REG_UART]),
		.wb_rsp_o  (wb_rsp[`SOC_REG_UART]),
		.uart_tx_o (uart_tx_o)
	);

	soc_led_pwm i_led (
		.clk_24m  (clk_24m),
		.rst      (rst),
		.wb_req_i (wb_req),
		.wb_cyc_i (wb_cyc[`SOC_REG_LED]),
		.wb_rsp_o (wb_rsp[`SOC_REG_LED]),
		.ch_en_i  (ch_en),
		.rgb_o    (rgb_o)
	);

endmodule

// File: design/soc_led_pwm.sv
// RGB LED PWM, three channels

`timescale 1ns/1ns

module soc_led_pwm (
	input  logic              clk_24m,
	input  logic              rst,
	input  soc_pkg::wb_req_t  wb_req_i,
	input  logic              wb_cyc_i,
	output soc_pkg::wb_rsp_t  wb_rsp_o,
	input  logic [2:0]        ch_en_i,
	output logic [2:0]        rgb_o
);
	logic [2:0][7:0] duty_q;
	logic [7:0]      cnt_q;
	logic            ack_q;
	logic [31:0]     rdata;

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			ack_q <= 1'b0;
			duty_q <= '0;
			cnt_q <= 8'd0;
		end else begin
			ack_q <= wb_cyc_i & ~ack_q;
			cnt_q <= cnt_q + 8'd1;
			if (wb_cyc_i && !ack_q && wb_req_i.we) begin
				case (wb_req_i.addr)
					4'd0:    duty_q[0] <= wb_req_i.wdata[7:0];
					4'd1:    duty_q[1] <= wb_req_i.wdata[7:0];
					4'd2:    duty_q[2] <= wb_req_i.wdata[7:0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (wb_req_i.addr)
			4'd0:    rdata = {24'd0, duty_q[0]};
			4'd1:    rdata = {24'd0, duty_q[1]};
			4'd2:    rdata = {24'd0, duty_q[2]};
			default: rdata = '0;
		endcase
	end

	// High for duty cycles out of every 256
	always_comb begin
		for (int k = 0; k < 3; k++)
			rgb_o[k] = ch_en_i[k] && (cnt_q < duty_q[k]);
	end

	assign wb_rsp_o = '{ack: ack_q, rdata: rdata};

endmodule

// File: design/soc_uart_tx.sv
// UART transmitter, 8N1

`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_uart_tx (
	input  logic              clk_24m,
	input  logic              rst,
	input  soc_pkg::wb_req_t  wb_req_i,
	input  logic              wb_cyc_i,
	output soc_pkg::wb_rsp_t  wb_rsp_o,
	output logic              uart_tx_o
);
	logic [`SOC_UART_DIV_W-1:0] div_q;
	logic [`SOC_UART_DIV_W-1:0] baud_cnt_q;
	logic [3:0]                 bit_cnt_q;
	logic [8:0]                 shift_q;
	logic                       ack_q;
	logic                       busy;
	logic                       wr_stb;
	logic                       start;
	logic                       tick;
	logic [31:0]                rdata;

	assign busy = bit_cnt_q != 4'd0;
	assign wr_stb = wb_cyc_i && !ack_q && wb_req_i.we;
	// Data writes while busy are lost
	assign start = wr_stb && (wb_req_i.addr == 4'd0) && !busy;
	assign tick = busy && (baud_cnt_q == '0);

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			ack_q <= 1'b0;
			div_q <= `SOC_UART_DIV_RESET;
			baud_cnt_q <= '0;
			bit_cnt_q <= 4'd0;
		end else begin
			ack_q <= wb_cyc_i & ~ack_q;
			if (wr_stb && (wb_req_i.addr == 4'd1))
				div_q <= wb_req_i.wdata[`SOC_UART_DIV_W-1:0];
			if (start) begin
				baud_cnt_q <= div_q;
				bit_cnt_q <= 4'd10;
			end else if (tick) begin
				baud_cnt_q <= div_q;
				bit_cnt_q <= bit_cnt_q - 4'd1;
			end else if (busy) begin
				baud_cnt_q <= baud_cnt_q - 1'b1;
			end
		end
	end

	// Start bit in LSB, stop bit shifted in from the top
	always_ff @(posedge clk_24m) begin
		if (start)
			shift_q <= {wb_req_i.wdata[7:0], 1'b0};
		else if (tick)
			shift_q <= {1'b1, shift_q[8:1]};
	end

	always_comb begin
		case (wb_req_i.addr)
			4'd0:    rdata = {31'd0, busy};
			4'd1:    rdata = {{(32-`SOC_UART_DIV_W){1'b0}}, div_q};
			default: rdata = '0;
		endcase
	end

	assign wb_rsp_o = '{ack: ack_q, rdata: rdata};
	assign uart_tx_o = busy ? shift_q[0] : 1'b1;

endmodule

// File: design/soc_ctrl_regs.sv
// LED enable and warm-boot control

`timescale 1ns/1ns

module soc_ctrl_regs (
	input  logic                clk_24m,
	input  logic                rst,
	input  soc_pkg::wb_req_t    wb_req_i,
	input  logic                wb_cyc_i,
	output soc_pkg::wb_rsp_t    wb_rsp_o,
	output logic [2:0]          ch_en_o,
	output soc_pkg::boot_req_t  boot_o
);
	soc_pkg::ctrl_word_u wr_word;
	soc_pkg::led_ctrl_t  led_q;
	soc_pkg::boot_ctrl_t boot_q;
	logic                ack_q;
	logic [31:0]         rdata;

	assign wr_word = wb_req_i.wdata;

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			ack_q <= 1'b0;
			led_q <= '0;
			boot_q <= '0;
		end else begin
			ack_q <= wb_cyc_i & ~ack_q;
			if (wb_cyc_i && !ack_q && wb_req_i.we) begin
				case (wb_req_i.addr)
					4'd0: led_q.ch_en <= wr_word.led.ch_en;
					4'd1: begin
						boot_q.now <= wr_word.boot.now;
						boot_q.sel <= wr_word.boot.sel;
					end
					default: ;
				endcase
			end
		end
	end

	// Reserved bits never get written
	always_comb begin
		case (wb_req_i.addr)
			4'd0:    rdata = led_q;
			4'd1:    rdata = boot_q;
			default: rdata = '0;
		endcase
	end

	assign wb_rsp_o = '{ack: ack_q, rdata: rdata};
	assign ch_en_o = led_q.ch_en;
	assign boot_o = '{now: boot_q.now, sel: boot_q.sel};

endmodule

// File: design/soc_bram.sv
// Boot RAM, byte masked, registered read

`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_bram (
	input  logic               clk_24m,
	input  soc_pkg::bram_req_t req_i,
	output logic [31:0]        rdata_o
);
	logic [31:0] mem [2**`SOC_BRAM_AW];

	always_ff @(posedge clk_24m) begin
		for (int b = 0; b < 4; b++) begin
			if (req_i.we && req_i.wmsk[b])
				mem[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
		end
		// Old word on a write
		rdata_o <= mem[req_i.addr];
	end

endmodule

// File: design/soc_bus_bridge.sv
// Core bus to boot RAM and Wishbone bridge

`timescale 1ns/1ns
`include "soc_consts.svh"

module soc_bus_bridge (
	input  logic                  clk_24m,
	input  logic                  rst,
	input  soc_pkg::mem_req_t     mem_req_i,
	output soc_pkg::mem_rsp_t     mem_rsp_o,
	output soc_pkg::bram_req_t    bram_req_o,
	input  logic [31:0]           bram_rdata_i,
	output soc_pkg::wb_req_t      wb_req_o,
	output logic [`SOC_WB_N-1:0]  wb_cyc_o,
	input  soc_pkg::wb_rsp_t      wb_rsp_i [`SOC_WB_N]
);
	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_BRAM = 3'd1;
	localparam logic [2:0] ST_NONE = 3'd2;
	localparam logic [2:0] ST_WAIT = 3'd3;
	localparam logic [2:0] ST_DONE = 3'd4;

	logic [2:0]           state_q;
	logic [`SOC_WB_N-1:0] cyc_q;
	logic [`SOC_WB_N-1:0] slv_sel;
	logic [31:0]          wb_rdata_q;
	logic [31:0]          rsp_rdata;
	logic [31:0]          ack_rdata;
	logic                 ack;
	logic                 is_bram;
	logic                 is_wb;
	logic                 wr;

	assign is_bram = mem_req_i.addr[31:30] == `SOC_REGION_BRAM;
	// Slave index 3 falls into the empty region
	assign is_wb = (mem_req_i.addr[31:30] == `SOC_REGION_WB) &&
		(mem_req_i.addr[17:16] < `SOC_WB_N);
	assign wr = |mem_req_i.wstrb;

	always_comb begin
		for (int k = 0; k < `SOC_WB_N; k++)
			slv_sel[k] = mem_req_i.addr[17:16] == 2'(k);
	end

	// RAM writes only on the accepting edge
	assign bram_req_o = '{
		addr:  mem_req_i.addr[`SOC_BRAM_AW+1:2],
		wdata: mem_req_i.wdata,
		wmsk:  mem_req_i.wstrb,
		we:    (state_q == ST_IDLE) && mem_req_i.valid && is_bram && wr
	};

	assign wb_req_o = '{
		addr:  mem_req_i.addr[`SOC_WB_AW+1:2],
		wdata: mem_req_i.wdata,
		we:    wr
	};
	assign wb_cyc_o = cyc_q;

	always_comb begin
		ack = 1'b0;
		ack_rdata = '0;
		for (int k = 0; k < `SOC_WB_N; k++) begin
			if (cyc_q[k] && wb_rsp_i[k].ack) begin
				ack = 1'b1;
				ack_rdata = wb_rsp_i[k].rdata;
			end
		end
	end

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			state_q <= ST_IDLE;
			cyc_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (mem_req_i.valid) begin
						if (is_bram) begin
							state_q <= ST_BRAM;
						end else if (is_wb) begin
							state_q <= ST_WAIT;
							cyc_q <= slv_sel;
						end else begin
							state_q <= ST_NONE;
						end
					end
				end
				ST_WAIT: begin
					if (ack) begin
						state_q <= ST_DONE;
						cyc_q <= '0;
					end
				end
				// Reply states last one cycle
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_24m) begin
		if (ack)
			wb_rdata_q <= ack_rdata;
	end

	always_comb begin
		case (state_q)
			ST_BRAM: rsp_rdata = bram_rdata_i;
			ST_DONE: rsp_rdata = wb_rdata_q;
			default: rsp_rdata = '0;
		endcase
	end

	assign mem_rsp_o = '{
		ready: (state_q == ST_BRAM) || (state_q == ST_NONE) || (state_q == ST_DONE),
		rdata: rsp_rdata
	};

endmodule

// File: design/soc_pkg.sv
// SoC bus and register types

`include "soc_consts.svh"

package soc_pkg;

	// Core native bus, zero strobe is a read
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} mem_req_t;

	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic [`SOC_BRAM_AW-1:0] addr;
		logic [31:0]             wdata;
		logic [3:0]              wmsk;
		logic                    we;
	} bram_req_t;

	typedef struct packed {
		logic [`SOC_WB_AW-1:0] addr;
		logic [31:0]           wdata;
		logic                  we;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] rdata;
	} wb_rsp_t;

	typedef struct packed {
		logic [28:0] rsvd;
		logic [2:0]  ch_en;
	} led_ctrl_t;

	typedef struct packed {
		logic [28:0] rsvd;
		logic        now;
		logic [1:0]  sel;
	} boot_ctrl_t;

	// Same word, two views depending on register
	typedef union packed {
		led_ctrl_t  led;
		boot_ctrl_t boot;
	} ctrl_word_u;

	typedef struct packed {
		logic       now;
		logic [1:0] sel;
	} boot_req_t;

endpackage

// File: design/soc_consts.svh
// SoC peripheral constants
// Widths, address map and reset values

`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Boot RAM word address
`define SOC_BRAM_AW 8

// Wishbone slaves
`define SOC_WB_N  3
`define SOC_WB_AW 4

`define SOC_REG_CTRL 0
`define SOC_REG_UART 1
`define SOC_REG_LED  2

// Region codes on address bits 31:30
`define SOC_REGION_BRAM 2'd0
`define SOC_REGION_WB   2'd2

// 115200 baud at 24 MHz
`define SOC_UART_DIV_W     12
`define SOC_UART_DIV_RESET 12'd207

`endif
